/* design/shell_consts.svh */
////////////////////////////////////////////////////////////
// Platform shell constants
// Bus widths, download indices, power-up values of the
// configuration registers and the sync placement used when
// rebuilding sync from the core's blanking signals
////////////////////////////////////////////////////////////

`ifndef SHELL_CONSTS_SVH
`define SHELL_CONSTS_SVH

////////////////////////////////////////////////////////////
// Download stream
////////////////////////////////////////////////////////////

// Word address of the host download, wide mode steps by two
`define SHELL_ADDR_W 27
`define SHELL_DATA_W 16
`define SHELL_INDEX_W 16

// Index 1 carries the title number, 254 carries the DIP banks
`define SHELL_IDX_TITLE 16'd1
`define SHELL_IDX_DIPS 16'd254

// Values seen before the host has sent any configuration
`define SHELL_DIP0_RST 8'hFC
`define SHELL_DIP1_RST 8'hFC
`define SHELL_DIP2_RST 4'hF
`define SHELL_TNO_RST 4'd1

////////////////////////////////////////////////////////////
// Sync and crop
////////////////////////////////////////////////////////////

// Pixel position inside horizontal blank where hsync starts
`define SHELL_HS_START 9
`define SHELL_HS_WIDTH 28

// Line position inside vertical blank where vsync starts
`define SHELL_VS_START 14
`define SHELL_VS_WIDTH 3

// Visible height in the 5x integer 216p mode
`define SHELL_CROP_LINES 216

`endif

/* design/shell_pkg.sv */
////////////////////////////////////////////////////////////
// Platform shell types
// Enumerations shared by the download receiver, the write
// bus and the configuration registers
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

package shell_pkg;

	////////////////////////////////////////////////////////////
	// Download targets
	////////////////////////////////////////////////////////////

	// Where a decoded download word is meant to go
	// DL_ROM is index 0, acknowledged but not stored here
	// DL_TITLE selects the game variant
	// DL_DIPS holds the three switch banks
	// DL_OTHER covers every index the shell does not know
	typedef enum logic [1:0] {
		DL_ROM   = 2'd0,
		DL_TITLE = 2'd1,
		DL_DIPS  = 2'd2,
		DL_OTHER = 2'd3
	} dl_target_e;

	////////////////////////////////////////////////////////////
	// Handshake state
	////////////////////////////////////////////////////////////

	// DL_IDLE waits for a request, DL_ACKED waits for release
	typedef enum logic {
		DL_IDLE  = 1'b0,
		DL_ACKED = 1'b1
	} dl_state_e;

endpackage

`default_nettype wire

/* design/dl_write_if.sv */
////////////////////////////////////////////////////////////
// Download write bus
// One decoded download word passed from the handshake
// receiver to the configuration registers
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

interface dl_write_if;

	// Single cycle strobe, one per completed transfer
	logic wr;
	// Destination decoded from the download index
	shell_pkg::dl_target_e target;
	logic [`SHELL_ADDR_W-1:0] addr;
	logic [`SHELL_DATA_W-1:0] data;

	// Receiver side
	modport src (output wr, target, addr, data);

	// Register side
	modport dst (input wr, target, addr, data);

endinterface

`default_nettype wire

/* design/download_port.sv */
////////////////////////////////////////////////////////////
// Download handshake receiver
// Accepts host words over a four-phase req/ack handshake,
// decodes the download index and issues one write per
// transfer on the write bus
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module download_port (
	input  logic                      CLK_VIDEO,
	input  logic                      rst_n,
	input  logic                      dl_req,
	input  logic [`SHELL_INDEX_W-1:0] dl_index,
	input  logic [`SHELL_ADDR_W-1:0]  dl_addr,
	input  logic [`SHELL_DATA_W-1:0]  dl_data,
	output logic                      dl_ack,
	dl_write_if.src                   wr_bus
);

	shell_pkg::dl_state_e  state;
	shell_pkg::dl_target_e target_dec;
	logic                  take;

	// Index decode, ROM data is still acknowledged so the host
	// never stalls on it
	always_comb begin
		case (dl_index)
			'0:               target_dec = shell_pkg::DL_ROM;
			`SHELL_IDX_TITLE: target_dec = shell_pkg::DL_TITLE;
			`SHELL_IDX_DIPS:  target_dec = shell_pkg::DL_DIPS;
			default:          target_dec = shell_pkg::DL_OTHER;
		endcase
	end

	// A request seen while idle is accepted on this edge
	assign take = (state == shell_pkg::DL_IDLE) && dl_req;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			state     <= shell_pkg::DL_IDLE;
			wr_bus.wr <= 1'b0;
		end else begin
			// The write strobe lives for the cycle in which ack rises
			wr_bus.wr <= take;
			if (take) begin
				state <= shell_pkg::DL_ACKED;
			end else if (state == shell_pkg::DL_ACKED && !dl_req) begin
				state <= shell_pkg::DL_IDLE;
			end
		end
	end

	// Ack is the state itself, so it follows req by one edge each way
	assign dl_ack = (state == shell_pkg::DL_ACKED);

	// Payload is captured while the host still holds it stable
	always_ff @(posedge CLK_VIDEO) begin
		if (take) begin
			wr_bus.target <= target_dec;
			wr_bus.addr   <= dl_addr;
			wr_bus.data   <= dl_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Ack may only rise in answer to a request sampled high
	a_ack_after_req: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		$rose(dl_ack) |-> $past(dl_req));

	// One transfer gives exactly one write strobe
	a_wr_single: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		wr_bus.wr |=> !wr_bus.wr);

endmodule

`default_nettype wire

/* design/config_capture.sv */
////////////////////////////////////////////////////////////
// Configuration registers
// DIP-switch banks and title number loaded from decoded
// download writes
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module config_capture (
	input  logic       CLK_VIDEO,
	input  logic       rst_n,
	dl_write_if.dst    wr_bus,
	output logic [7:0] dip0,
	output logic [7:0] dip1,
	output logic [3:0] dip2,
	output logic [3:0] tno
);

	logic dip_word_ok;

	// DIP data only lives in the first two words of its download
	assign dip_word_ok = (wr_bus.addr[`SHELL_ADDR_W-1:2] == '0);

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			dip0 <= `SHELL_DIP0_RST;
			dip1 <= `SHELL_DIP1_RST;
			dip2 <= `SHELL_DIP2_RST;
			tno  <= `SHELL_TNO_RST;
		end else if (wr_bus.wr) begin
			case (wr_bus.target)
				shell_pkg::DL_DIPS: begin
					// Word 0 holds banks 0 and 1, word 1 holds bank 2
					if (dip_word_ok && !wr_bus.addr[1]) begin
						dip0 <= wr_bus.data[7:0];
						dip1 <= wr_bus.data[15:8];
					end else if (dip_word_ok) begin
						dip2 <= wr_bus.data[3:0];
					end
				end
				// Title number, 1 for the first variant, 2 for the second
				shell_pkg::DL_TITLE: tno <= wr_bus.data[3:0];
				default: ;
			endcase
		end
	end

	// Nothing may move these registers except a write strobe
	a_cfg_hold: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		!$past(wr_bus.wr) |-> $stable({dip0, dip1, dip2, tno}));

endmodule

`default_nettype wire

/* design/sync_regen.sv */
////////////////////////////////////////////////////////////
// Sync regenerator
// Places clean hsync and vsync pulses inside the blanking
// intervals of the core, shifted by the user's signed
// horizontal and vertical offsets
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module sync_regen (
	input  logic              CLK_VIDEO,
	input  logic              rst_n,
	input  logic              ce_pix,
	input  logic              hblank,
	input  logic              vblank,
	input  logic signed [3:0] hs_offset,
	input  logic signed [3:0] vs_offset,
	output logic              hsync,
	output logic              vsync
);

	// Pixel count inside hblank and line count inside vblank
	logic [7:0] hb_cnt;
	logic [7:0] vb_cnt;

	// Pulse edges after applying the offsets
	logic [7:0] hs_on;
	logic [7:0] hs_off;
	logic [7:0] vs_on;
	logic [7:0] vs_off;
	logic       hs_rise_hit;
	logic       hs_fall_hit;

	// Offsets are sign extended so negative values move sync earlier
	assign hs_on  = 8'(`SHELL_HS_START) + {{4{hs_offset[3]}}, hs_offset};
	assign hs_off = hs_on + 8'(`SHELL_HS_WIDTH);
	assign vs_on  = 8'(`SHELL_VS_START) + {{4{vs_offset[3]}}, vs_offset};
	assign vs_off = vs_on + 8'(`SHELL_VS_WIDTH);

	// Both edges only count on a pixel strobe inside hblank
	assign hs_rise_hit = hblank && ce_pix && (hb_cnt == hs_on);
	assign hs_fall_hit = hblank && ce_pix && (hb_cnt == hs_off);

	////////////////////////////////////////////////////////////
	// Counters and pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			hb_cnt <= '0;
			vb_cnt <= '0;
			hsync  <= 1'b0;
			vsync  <= 1'b0;
		end else begin
			// Pixel counter restarts on every active line
			if (!hblank) begin
				hb_cnt <= '0;
			end else if (ce_pix) begin
				hb_cnt <= hb_cnt + 8'd1;
			end

			// Vsync edges are aligned to hsync rises
			if (hs_rise_hit) begin
				hsync <= 1'b1;
				if (vb_cnt == vs_on) begin
					vsync <= 1'b1;
				end
				if (vb_cnt == vs_off) begin
					vsync <= 1'b0;
				end
			end

			// A blank line is counted when its hsync ends
			if (hs_fall_hit) begin
				hsync <= 1'b0;
				if (vblank) begin
					vb_cnt <= vb_cnt + 8'd1;
				end
			end

			// Line counter restarts during active video
			if (!vblank) begin
				vb_cnt <= '0;
			end
		end
	end

	// Sync must start on a pixel strobe inside horizontal blank
	a_hs_in_blank: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		$rose(hsync) |-> $past(hblank && ce_pix));

endmodule

`default_nettype wire

/* design/display_setup.sv */
////////////////////////////////////////////////////////////
// Display settings
// Turns the menu's display options and the HDMI mode into
// aspect, scanline, scandoubler and 216p crop settings
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module display_setup (
	input  logic        CLK_VIDEO,
	input  logic        rst_n,
	input  logic [1:0]  aspect,
	input  logic [2:0]  scale_fx,
	input  logic        vcrop_en,
	input  logic [3:0]  crop_opt,
	input  logic        forced_scandoubler,
	input  logic [11:0] hdmi_width,
	input  logic [11:0] hdmi_height,
	output logic [11:0] arx,
	output logic [11:0] ary,
	output logic [9:0]  crop_size,
	output logic [4:0]  crop_off,
	output logic [1:0]  scanlines,
	output logic        scandoubler,
	output logic        hq2x
);

	// High when a 1080p output can take the 5x integer crop
	logic en216p;

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			en216p   <= 1'b0;
			crop_off <= '0;
		end else begin
			// Only a plain, non doubled picture is cropped
			en216p <= (hdmi_width == 12'd1920) && (hdmi_height == 12'd1080) &&
				!forced_scandoubler && (scale_fx == 3'd0);
			// Options 6 and up are the negative offsets, -12 to -2
			crop_off <= (crop_opt < 4'd6) ? {crop_opt, 1'b0} :
				({crop_opt, 1'b0} - 5'd24);
		end
	end

	assign crop_size = (en216p && vcrop_en) ? 10'(`SHELL_CROP_LINES) : 10'd0;

	// Aspect 0 is the original 4:3, the others select custom ratios
	assign arx = (aspect == 2'd0) ? 12'd4 : ({10'd0, aspect} - 12'd1);
	assign ary = (aspect == 2'd0) ? 12'd3 : 12'd0;

	// Filter 1 is HQ2x, filters 2 to 4 are the CRT scanline levels
	assign scanlines   = (scale_fx != 3'd0) ? 2'(scale_fx - 3'd1) : 2'd0;
	assign scandoubler = (scale_fx != 3'd0) || forced_scandoubler;
	assign hq2x        = (scale_fx == 3'd1);

endmodule

`default_nettype wire

/* design/shell_top.sv */
////////////////////////////////////////////////////////////
// Platform shell top level
// Download handshake and configuration registers, sync
// regeneration and display settings behind plain ports
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module shell_top (
	// Clock and download
	input  logic                      CLK_VIDEO,
	input  logic                      rst_n,
	input  logic                      dl_req,
	input  logic [`SHELL_INDEX_W-1:0] dl_index,
	input  logic [`SHELL_ADDR_W-1:0]  dl_addr,
	input  logic [`SHELL_DATA_W-1:0]  dl_data,
	output logic                      dl_ack,
	// Configuration out
	output logic [7:0]                dip0,
	output logic [7:0]                dip1,
	output logic [3:0]                dip2,
	output logic [3:0]                tno,
	// Video timing in
	input  logic                      ce_pix,
	input  logic                      hblank,
	input  logic                      vblank,
	input  logic signed [3:0]         hs_offset,
	input  logic signed [3:0]         vs_offset,
	// Sync out
	output logic                      hsync,
	output logic                      vsync,
	// Menu display options
	input  logic [1:0]                aspect,
	input  logic [2:0]                scale_fx,
	input  logic                      vcrop_en,
	input  logic [3:0]                crop_opt,
	input  logic                      forced_scandoubler,
	input  logic [11:0]               hdmi_width,
	input  logic [11:0]               hdmi_height,
	// Scaler settings
	output logic [11:0]               arx,
	output logic [11:0]               ary,
	output logic [9:0]                crop_size,
	output logic [4:0]                crop_off,
	output logic [1:0]                scanlines,
	output logic                      scandoubler,
	output logic                      hq2x
);

	// Decoded download writes
	dl_write_if wr_bus ();

	download_port u_port (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.dl_req    (dl_req),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_ack    (dl_ack),
		.wr_bus    (wr_bus.src)
	);

	config_capture u_cfg (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.wr_bus    (wr_bus.dst),
		.dip0      (dip0),
		.dip1      (dip1),
		.dip2      (dip2),
		.tno       (tno)
	);

	sync_regen u_sync (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix),
		.hblank    (hblank),
		.vblank    (vblank),
		.hs_offset (hs_offset),
		.vs_offset (vs_offset),
		.hsync     (hsync),
		.vsync     (vsync)
	);

	display_setup u_disp (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst_n              (rst_n),
		.aspect             (aspect),
		.scale_fx           (scale_fx),
		.vcrop_en           (vcrop_en),
		.crop_opt           (crop_opt),
		.forced_scandoubler (forced_scandoubler),
		.hdmi_width         (hdmi_width),
		.hdmi_height        (hdmi_height),
		.arx                (arx),
		.ary                (ary),
		.crop_size          (crop_size),
		.crop_off           (crop_off),
		.scanlines          (scanlines),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x)
	);

endmodule

`default_nettype wire

/* verification/tb_shell_top.sv */
////////////////////////////////////////////////////////////
// Platform shell testbench
// Drives download transfers, short blanking frames and menu
// settings into the shell and compares every output with
// models built from the shell's rules
////////////////////////////////////////////////////////////

`default_nettype none

`include "shell_consts.svh"

module tb_shell_top;

	// Test line is 20 active and 52 blank pixels
	localparam int ACTIVE_PIX   = 20;
	localparam int BLANK_PIX    = 52;
	// Test frame is 4 active and 28 blank lines
	localparam int ACTIVE_LINES = 4;
	localparam int BLANK_LINES  = 28;
	localparam int FRAMES       = 4;
	localparam int TRANSFERS    = 200;
	localparam int DISP_TRIALS  = 100;
	localparam int ACK_LIMIT    = 16;
	// 4 frames take 9216 cycles and 200 transfers at most about 2000
	localparam int TIMEOUT_CYCLES = 20000;

	logic                      CLK_VIDEO;
	logic                      rst_n;
	logic                      dl_req;
	logic [`SHELL_INDEX_W-1:0] dl_index;
	logic [`SHELL_ADDR_W-1:0]  dl_addr;
	logic [`SHELL_DATA_W-1:0]  dl_data;
	logic                      dl_ack;
	logic [7:0]                dip0;
	logic [7:0]                dip1;
	logic [3:0]                dip2;
	logic [3:0]                tno;
	logic                      ce_pix;
	logic                      hblank;
	logic                      vblank;
	logic signed [3:0]         hs_offset;
	logic signed [3:0]         vs_offset;
	logic                      hsync;
	logic                      vsync;
	logic [1:0]                aspect;
	logic [2:0]                scale_fx;
	logic                      vcrop_en;
	logic [3:0]                crop_opt;
	logic                      forced_scandoubler;
	logic [11:0]               hdmi_width;
	logic [11:0]               hdmi_height;
	logic [11:0]               arx;
	logic [11:0]               ary;
	logic [9:0]                crop_size;
	logic [4:0]                crop_off;
	logic [1:0]                scanlines;
	logic                      scandoubler;
	logic                      hq2x;

	int errors;
	int checks;
	int cycle_count;

	// Expected configuration registers
	logic [7:0] m_dip0;
	logic [7:0] m_dip1;
	logic [3:0] m_dip2;
	logic [3:0] m_tno;

	// Every port has a testbench signal of the same name
	shell_top u_dut (.*);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #4 CLK_VIDEO = ~CLK_VIDEO;
	end

	// Watchdog that ends a stalled run
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK_VIDEO);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_count);
		$display("FAIL: see errors above");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Handshake checks
	////////////////////////////////////////////////////////////

	// Ack rises only after a request was sampled high
	a_ack_rise: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		$rose(dl_ack) |-> $past(dl_req))
	else begin
		errors++;
		$display("Handshake error: dl_ack rose while dl_req was low");
	end

	// Ack falls only after the request was released
	a_ack_fall: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		$fell(dl_ack) |-> !$past(dl_req))
	else begin
		errors++;
		$display("Handshake error: dl_ack fell while dl_req was high");
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Inputs change one time unit after the rising edge
	task automatic next_cycle();
		@(posedge CLK_VIDEO);
		#1;
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual == expected)
		else begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
		end
	endtask

	// Waits for dl_ack to reach a level and reports how many edges it took
	task automatic wait_for_ack(input logic level, output int waited);
		waited = 0;
		while (dl_ack !== level && waited < ACK_LIMIT) begin
			next_cycle();
			waited++;
		end
		checks++;
		assert (dl_ack === level)
		else begin
			errors++;
			$display("Handshake stalled: dl_ack did not reach %0b in %0d cycles",
				level, ACK_LIMIT);
		end
	endtask

	// Capture rule, DIP words live at addresses 0 and 2 of index 254
	task automatic update_config_model(input logic [15:0] index, input logic [26:0] addr,
		input logic [15:0] data);
		if (index == `SHELL_IDX_DIPS && addr[`SHELL_ADDR_W-1:2] == '0) begin
			if (!addr[1]) begin
				m_dip0 = data[7:0];
				m_dip1 = data[15:8];
			end else begin
				m_dip2 = data[3:0];
			end
		end else if (index == `SHELL_IDX_TITLE) begin
			m_tno = data[3:0];
		end
	endtask

	task automatic check_config(input string phase);
		check_value({phase, " dip0"}, 32'(m_dip0), 32'(dip0));
		check_value({phase, " dip1"}, 32'(m_dip1), 32'(dip1));
		check_value({phase, " dip2"}, 32'(m_dip2), 32'(dip2));
		check_value({phase, " tno"}, 32'(m_tno), 32'(tno));
	endtask

	// One four-phase transfer, the host holds req for a few extra cycles
	task automatic send_transfer(input logic [15:0] index, input logic [26:0] addr,
		input logic [15:0] data, input int release_delay);
		int waited;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		dl_req   = 1'b1;
		update_config_model(index, addr, data);
		wait_for_ack(1'b1, waited);
		check_value("ack rise latency", 1, waited);
		// The payload may change once ack is seen
		dl_index = 16'($urandom);
		dl_addr  = 27'($urandom);
		dl_data  = 16'($urandom);
		// Registers show the word one edge after ack rose
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_config("capture");
		next_cycle();
		repeat (release_delay) next_cycle();
		dl_req = 1'b0;
		wait_for_ack(1'b0, waited);
		check_value("ack fall latency", 1, waited);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic run_transfers();
		logic [15:0] index;
		logic [26:0] addr;
		int          kind;
		for (int t = 0; t < TRANSFERS; t++) begin
			kind = $urandom_range(0, 3);
			case (kind)
				0: index = 16'd0;
				1: index = `SHELL_IDX_TITLE;
				2: index = `SHELL_IDX_DIPS;
				default: index = 16'($urandom_range(2, 253));
			endcase
			// Mostly the two DIP words, sometimes any address
			addr = ($urandom_range(0, 3) == 0) ? 27'($urandom) : 27'($urandom_range(0, 3));
			send_transfer(index, addr, 16'($urandom), $urandom_range(0, 3));
		end
	endtask

	// Full frames with ce_pix in every cycle and new offsets per frame
	task automatic run_sync_frames();
		int   hs_on;
		int   vs_on;
		int   hs_high;
		int   vs_lines;
		logic exp_hs;
		logic exp_vs;
		exp_hs = 1'b0;
		exp_vs = 1'b0;
		ce_pix = 1'b1;
		for (int f = 0; f < FRAMES; f++) begin
			hs_offset = 4'($urandom);
			vs_offset = 4'($urandom);
			hs_on     = `SHELL_HS_START + int'(hs_offset);
			vs_on     = `SHELL_VS_START + int'(vs_offset);
			vs_lines  = 0;
			for (int l = 0; l < ACTIVE_LINES + BLANK_LINES; l++) begin
				hs_high = 0;
				for (int c = 0; c < ACTIVE_PIX + BLANK_PIX; c++) begin
					hblank = (c >= ACTIVE_PIX);
					vblank = (l >= ACTIVE_LINES);
					@(negedge CLK_VIDEO);
					check_value("hsync", 32'(exp_hs), 32'(hsync));
					check_value("vsync", 32'(exp_vs), 32'(vsync));
					if (hsync) hs_high++;
					next_cycle();
					// The edge just taken closed blank pixel c - ACTIVE_PIX
					if (c - ACTIVE_PIX == hs_on) begin
						exp_hs = 1'b1;
						if (l - ACTIVE_LINES == vs_on) exp_vs = 1'b1;
						if (l - ACTIVE_LINES == vs_on + `SHELL_VS_WIDTH) exp_vs = 1'b0;
					end
					if (c - ACTIVE_PIX == hs_on + `SHELL_HS_WIDTH) exp_hs = 1'b0;
				end
				check_value("hsync width", `SHELL_HS_WIDTH, hs_high);
				if (vsync) vs_lines++;
			end
			check_value("vsync width", `SHELL_VS_WIDTH, vs_lines);
		end
		hblank = 1'b0;
		vblank = 1'b0;
		ce_pix = 1'b0;
	endtask

	task automatic run_display_trials();
		int sfx;
		int co;
		int asp;
		int en;
		for (int t = 0; t < DISP_TRIALS; t++) begin
			aspect             = 2'($urandom);
			scale_fx           = ($urandom_range(0, 1) == 0) ? 3'd0 : 3'($urandom);
			vcrop_en           = 1'($urandom);
			crop_opt           = 4'($urandom);
			forced_scandoubler = ($urandom_range(0, 3) == 0);
			// Favour the 1080p mode so the crop path is reached
			if ($urandom_range(0, 2) != 0) begin
				hdmi_width  = 12'd1920;
				hdmi_height = 12'd1080;
			end else begin
				hdmi_width  = 12'($urandom);
				hdmi_height = 12'($urandom);
			end
			sfx = int'(scale_fx);
			co  = int'(crop_opt);
			asp = int'(aspect);
			en  = (hdmi_width == 12'd1920 && hdmi_height == 12'd1080 &&
				!forced_scandoubler && sfx == 0) ? 1 : 0;
			@(posedge CLK_VIDEO);
			@(negedge CLK_VIDEO);
			check_value("crop_size", (en == 1 && vcrop_en) ? `SHELL_CROP_LINES : 0,
				32'(crop_size));
			check_value("crop_off", (co < 6) ? 2 * co : ((2 * co - 24) & 31), 32'(crop_off));
			check_value("arx", (asp == 0) ? 4 : asp - 1, 32'(arx));
			check_value("ary", (asp == 0) ? 3 : 0, 32'(ary));
			check_value("scanlines", (sfx != 0) ? ((sfx - 1) & 3) : 0, 32'(scanlines));
			check_value("scandoubler", (sfx != 0 || forced_scandoubler) ? 1 : 0,
				32'(scandoubler));
			check_value("hq2x", (sfx == 1) ? 1 : 0, 32'(hq2x));
			next_cycle();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		void'($urandom(32'heb44));
		rst_n              = 1'b0;
		dl_req             = 1'b0;
		dl_index           = '0;
		dl_addr            = '0;
		dl_data            = '0;
		ce_pix             = 1'b0;
		hblank             = 1'b0;
		vblank             = 1'b0;
		hs_offset          = '0;
		vs_offset          = '0;
		aspect             = '0;
		scale_fx           = '0;
		vcrop_en           = 1'b0;
		crop_opt           = '0;
		forced_scandoubler = 1'b0;
		hdmi_width         = '0;
		hdmi_height        = '0;
		m_dip0             = `SHELL_DIP0_RST;
		m_dip1             = `SHELL_DIP1_RST;
		m_dip2             = `SHELL_DIP2_RST;
		m_tno              = `SHELL_TNO_RST;

		repeat (8) @(posedge CLK_VIDEO);
		#1;
		rst_n = 1'b1;

		// Power-up state of the handshake, sync and registers
		@(negedge CLK_VIDEO);
		check_value("reset dl_ack", 0, 32'(dl_ack));
		check_value("reset hsync", 0, 32'(hsync));
		check_value("reset vsync", 0, 32'(vsync));
		check_config("reset");
		next_cycle();

		run_transfers();
		run_sync_frames();
		run_display_trials();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/shell_pkg.sv
design/dl_write_if.sv
design/download_port.sv
design/config_capture.sv
design/sync_regen.sv
design/display_setup.sv
design/shell_top.sv
verification/tb_shell_top.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --timing --assert
TOP      := tb_shell_top
RTL_TOP  := shell_top
FILELIST := compile.f
OBJ_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the simulation prints the pass line
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
